/* common/cpu_sm_macros.svh */
`ifndef CPU_SM_MACROS_SVH
`define CPU_SM_MACROS_SVH

// FIFO depth in longwords and the width of a 0..depth count
`define CPU_SM_FIFO_DEPTH 8
`define CPU_SM_CNT_W 4

// Whole-code states
`define CPU_SM_IDLE 5'd0
`define CPU_SM_REQ 5'd2
`define CPU_SM_WAIT_GRANT 5'd8
`define CPU_SM_ACK 5'd16
`define CPU_SM_RELEASE 5'd30

// Phase field values of the transfer states
`define CPU_SM_PH_ADDR 3'd1
`define CPU_SM_PH_DATA 3'd2
`define CPU_SM_PH_TERM 3'd3

`endif

/* common/cpu_sm_pkg.sv */
`default_nettype none

package cpu_sm_pkg;

    // Field view of the bus state word
    // phase 1 to 3 are the address, data and terminate phases of a transfer
    typedef struct packed {
        logic [2:0] phase;
        logic       dir;    // 1 = FIFO to bus
        logic       half;   // 1 = second half of a 16-bit longword
    } cpu_state_fields_t;

    // The state word is decoded whole for arbitration and by fields for transfers
    typedef union packed {
        logic [4:0]        code;
        cpu_state_fields_t fields;
    } cpu_state_u;

endpackage

`default_nettype wire

/* hw/fifo_ptr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module fifo_ptr_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inc_fifo,
    input  logic                     dec_fifo,
    input  logic                     fill,
    input  logic                     fill_full,
    output logic [`CPU_SM_CNT_W-1:0] fifo_count,
    output logic                     fifo_empty,
    output logic                     fifo_full
);

    localparam logic [`CPU_SM_CNT_W-1:0] DEPTH = `CPU_SM_FIFO_DEPTH;

    logic [`CPU_SM_CNT_W-1:0] count_nxt;
    logic                     up;

    assign up = inc_fifo | fill;

    // Saturating count, a simultaneous up and down cancels
    always_comb begin
        count_nxt = fifo_count;
        if (fill_full) begin
            count_nxt = DEPTH;
        end else if (up && !dec_fifo && fifo_count != DEPTH) begin
            count_nxt = fifo_count + 1'b1;
        end else if (dec_fifo && !up && fifo_count != '0) begin
            count_nxt = fifo_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fifo_count <= '0;
            fifo_empty <= 1'b1;
            fifo_full  <= 1'b0;
        end else begin
            fifo_count <= count_nxt;
            fifo_empty <= (count_nxt == '0);
            fifo_full  <= (count_nxt == DEPTH);
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_sm/cpu_sm_state.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module cpu_sm_state (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   dir,
    input  logic                   bgrant_n,
    input  logic                   dsack,
    input  logic                   sterm_n,
    input  logic                   fifo_empty,
    input  logic                   fifo_full,
    output cpu_sm_pkg::cpu_state_u state
);

    cpu_sm_pkg::cpu_state_u state_nxt;
    logic                   work;
    logic                   long_end;
    logic                   half_end;
    logic                   done;

    // Something to move in the requested direction
    assign work = dir ? ~fifo_empty : ~fifo_full;

    // Termination of the running bus cycle
    assign long_end = ~sterm_n | (dsack & state.fields.half);
    assign half_end = ~long_end & dsack;

    // FIFO exhausted for the latched direction
    assign done = state.fields.dir ? fifo_empty : fifo_full;

    always_comb begin
        state_nxt = state;
        if (state.code == `CPU_SM_IDLE) begin
            if (start && work) begin
                state_nxt.code = `CPU_SM_REQ;
            end
        end else if (state.code == `CPU_SM_REQ) begin
            state_nxt.code = bgrant_n ? `CPU_SM_WAIT_GRANT : `CPU_SM_ACK;
        end else if (state.code == `CPU_SM_WAIT_GRANT) begin
            if (!bgrant_n) begin
                state_nxt.code = `CPU_SM_ACK;
            end
        end else if (state.code == `CPU_SM_ACK) begin
            // Direction is held in the state word from here to release
            state_nxt.fields.phase = `CPU_SM_PH_ADDR;
            state_nxt.fields.dir   = dir;
            state_nxt.fields.half  = 1'b0;
        end else if (state.code == `CPU_SM_RELEASE) begin
            state_nxt.code = `CPU_SM_IDLE;
        end else if (state.fields.phase == `CPU_SM_PH_ADDR) begin
            if (long_end) begin
                state_nxt.fields.phase = `CPU_SM_PH_TERM;
                state_nxt.fields.half  = 1'b0;
            end else if (half_end) begin
                state_nxt.fields.phase = `CPU_SM_PH_TERM;
                state_nxt.fields.half  = 1'b1;
            end
        end else if (state.fields.phase == `CPU_SM_PH_TERM) begin
            if (state.fields.half) begin
                // Second half of a 16-bit longword follows
                state_nxt.fields.phase = `CPU_SM_PH_ADDR;
            end else begin
                // Wait here while the FIFO count settles
                state_nxt.fields.phase = `CPU_SM_PH_DATA;
                state_nxt.fields.half  = 1'b1;
            end
        end else if (state.fields.phase == `CPU_SM_PH_DATA && state.fields.half) begin
            if (done) begin
                state_nxt.code = `CPU_SM_RELEASE;
            end else begin
                state_nxt.fields.phase = `CPU_SM_PH_ADDR;
                state_nxt.fields.half  = 1'b0;
            end
        end else begin
            state_nxt.code = `CPU_SM_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state.code <= `CPU_SM_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_sm/cpu_sm_terms.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module cpu_sm_terms (
    input  cpu_sm_pkg::cpu_state_u state,
    input  logic                   dsack,
    input  logic                   sterm_n,
    output logic                   req_term,
    output logic                   ack_term,
    output logic                   addr_term,
    output logic                   data_term,
    output logic                   end_long_term,
    output logic                   end_half_term,
    output logic                   wr_dir
);

    logic in_addr;
    logic second_half;
    logic term_seen;

    // Arbitration states come from the whole code
    assign req_term = (state.code == `CPU_SM_REQ) | (state.code == `CPU_SM_WAIT_GRANT);
    assign ack_term = (state.code == `CPU_SM_ACK);

    // Transfer states come from the fields
    assign in_addr     = (state.fields.phase == `CPU_SM_PH_ADDR);
    assign second_half = state.fields.half;
    assign term_seen   = ~sterm_n | dsack;

    assign addr_term = in_addr;

    // Cycle still open, data not yet taken
    assign data_term = in_addr & ~term_seen;

    // sterm ends a whole longword, dsack only on the second half
    assign end_long_term = in_addr & (~sterm_n | (dsack & second_half));
    assign end_half_term = in_addr & sterm_n & dsack & ~second_half;

    assign wr_dir = state.fields.dir;

endmodule

`default_nettype wire

/* hw/cpu_sm/cpu_sm_outputs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module cpu_sm_outputs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_sm_pkg::cpu_state_u state,
    input  logic                   req_term,
    input  logic                   ack_term,
    input  logic                   addr_term,
    input  logic                   data_term,
    input  logic                   end_long_term,
    input  logic                   end_half_term,
    input  logic                   wr_dir,
    input  logic                   dsack,
    input  logic                   sterm_n,
    input  logic                   bgrant_n,
    output logic                   breq_n,
    output logic                   bgack_n,
    output logic                   as_n,
    output logic                   ds_n,
    output logic                   size1,
    output logic                   f2cpul,
    output logic                   f2cpuh,
    output logic                   pllw,
    output logic                   plhw,
    output logic                   inc_fifo,
    output logic                   dec_fifo
);

    logic breq_n_d;
    logic bgack_n_d;
    logic as_n_d;
    logic ds_n_d;
    logic size1_d;
    logic f2cpul_d;
    logic f2cpuh_d;
    logic pllw_d;
    logic plhw_d;
    logic inc_fifo_d;
    logic dec_fifo_d;

    logic low_strobe;
    logic high_strobe;
    logic arb_state;

    // Request held until the grant is seen
    assign breq_n_d = ~(req_term & bgrant_n);

    // Bus is ours from the grant until release
    assign arb_state = (state.code == `CPU_SM_REQ) | (state.code == `CPU_SM_WAIT_GRANT);
    assign bgack_n_d = (state.code == `CPU_SM_IDLE) |
                       (state.code == `CPU_SM_RELEASE) |
                       (arb_state & bgrant_n);

    // Strobes stay asserted through the whole bus cycle
    assign as_n_d = ~(ack_term | addr_term);
    assign ds_n_d = ~(ack_term | data_term | end_half_term | end_long_term);

    // Marks the upper word on a 16-bit port
    assign size1_d = addr_term & state.code[0];

    // A 32-bit termination latches both words at once
    assign low_strobe  = end_half_term | (end_long_term & ~sterm_n & ~dsack);
    assign high_strobe = end_long_term;

    assign f2cpul_d = low_strobe & wr_dir;
    assign f2cpuh_d = high_strobe & wr_dir;
    assign pllw_d   = low_strobe & ~wr_dir;
    assign plhw_d   = high_strobe & ~wr_dir;

    // One count step per finished longword
    assign inc_fifo_d = end_long_term & ~wr_dir;
    assign dec_fifo_d = end_long_term & wr_dir;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            breq_n   <= 1'b1;
            bgack_n  <= 1'b1;
            as_n     <= 1'b1;
            ds_n     <= 1'b1;
            size1    <= 1'b0;
            f2cpul   <= 1'b0;
            f2cpuh   <= 1'b0;
            pllw     <= 1'b0;
            plhw     <= 1'b0;
            inc_fifo <= 1'b0;
            dec_fifo <= 1'b0;
        end else begin
            breq_n   <= breq_n_d;
            bgack_n  <= bgack_n_d;
            as_n     <= as_n_d;
            ds_n     <= ds_n_d;
            size1    <= size1_d;
            f2cpul   <= f2cpul_d;
            f2cpuh   <= f2cpuh_d;
            pllw     <= pllw_d;
            plhw     <= plhw_d;
            inc_fifo <= inc_fifo_d;
            dec_fifo <= dec_fifo_d;
        end
    end

endmodule

`default_nettype wire

/* hw/sdmac_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module sdmac_cpu_bus (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     dir,
    input  logic                     bgrant_n,
    input  logic                     dsack,
    input  logic                     sterm_n,
    input  logic                     fill,
    input  logic                     fill_full,
    output logic                     breq_n,
    output logic                     bgack_n,
    output logic                     as_n,
    output logic                     ds_n,
    output logic                     size1,
    output logic                     f2cpul,
    output logic                     f2cpuh,
    output logic                     pllw,
    output logic                     plhw,
    output logic [`CPU_SM_CNT_W-1:0] fifo_count,
    output logic                     fifo_empty,
    output logic                     fifo_full
);

    cpu_sm_pkg::cpu_state_u state;

    logic req_term;
    logic ack_term;
    logic addr_term;
    logic data_term;
    logic end_long_term;
    logic end_half_term;
    logic wr_dir;
    logic inc_fifo;
    logic dec_fifo;

    cpu_sm_state state_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .dir        (dir),
        .bgrant_n   (bgrant_n),
        .dsack      (dsack),
        .sterm_n    (sterm_n),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .state      (state)
    );

    cpu_sm_terms terms_i (
        .state         (state),
        .dsack         (dsack),
        .sterm_n       (sterm_n),
        .req_term      (req_term),
        .ack_term      (ack_term),
        .addr_term     (addr_term),
        .data_term     (data_term),
        .end_long_term (end_long_term),
        .end_half_term (end_half_term),
        .wr_dir        (wr_dir)
    );

    cpu_sm_outputs outputs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .req_term      (req_term),
        .ack_term      (ack_term),
        .addr_term     (addr_term),
        .data_term     (data_term),
        .end_long_term (end_long_term),
        .end_half_term (end_half_term),
        .wr_dir        (wr_dir),
        .dsack         (dsack),
        .sterm_n       (sterm_n),
        .bgrant_n      (bgrant_n),
        .breq_n        (breq_n),
        .bgack_n       (bgack_n),
        .as_n          (as_n),
        .ds_n          (ds_n),
        .size1         (size1),
        .f2cpul        (f2cpul),
        .f2cpuh        (f2cpuh),
        .pllw          (pllw),
        .plhw          (plhw),
        .inc_fifo      (inc_fifo),
        .dec_fifo      (dec_fifo)
    );

    fifo_ptr_ctrl fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inc_fifo   (inc_fifo),
        .dec_fifo   (dec_fifo),
        .fill       (fill),
        .fill_full  (fill_full),
        .fifo_count (fifo_count),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

endmodule

`default_nettype wire

/* verification/sdmac_cpu_bus_props.sv */
`timescale 1ns/1ps
`default_nettype none

module sdmac_cpu_bus_props (
    input logic clk,
    input logic rst_n,
    input logic breq_n,
    input logic bgack_n,
    input logic as_n,
    input logic inc_fifo,
    input logic dec_fifo
);

    int unsigned prop_failures = 0;

    // Address strobe only while the bus is acknowledged
    as_needs_bgack: assert property (@(posedge clk) disable iff (!rst_n) !as_n |-> !bgack_n)
        else begin
            $error("as_n low while bgack_n is high");
            prop_failures++;
        end

    // Request drops as the acknowledge is taken
    req_ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n) breq_n || bgack_n)
        else begin
            $error("breq_n and bgack_n low together");
            prop_failures++;
        end

    fifo_one_step: assert property (@(posedge clk) disable iff (!rst_n) !(inc_fifo && dec_fifo))
        else begin
            $error("inc_fifo and dec_fifo high together");
            prop_failures++;
        end

endmodule

`default_nettype wire

/* verification/sdmac_cpu_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_sm_macros.svh"

module sdmac_cpu_bus_tb;

    localparam int TRANSFERS      = 40;
    localparam int TIMEOUT_CYCLES = TRANSFERS * `CPU_SM_FIFO_DEPTH * 2 * 14;
    localparam int RANDOM_RUNS    = 36;

    // f2cpul, f2cpuh, pllw, plhw, size1 halves, final fifo_count
    typedef logic [5:0][`CPU_SM_CNT_W-1:0] result_t;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    logic                     dir;
    logic                     bgrant_n;
    logic                     dsack;
    logic                     sterm_n;
    logic                     fill;
    logic                     fill_full;
    logic                     breq_n;
    logic                     bgack_n;
    logic                     as_n;
    logic                     ds_n;
    logic                     size1;
    logic                     f2cpul;
    logic                     f2cpuh;
    logic                     pllw;
    logic                     plhw;
    logic [`CPU_SM_CNT_W-1:0] fifo_count;
    logic                     fifo_empty;
    logic                     fifo_full;

    // Port width and stall for the running transfer
    logic port16;
    int   stall_cycles;

    result_t                       expected;
    logic [4:0][`CPU_SM_CNT_W-1:0] pulses;
    logic                          size1_q     = 1'b0;
    logic                          bgack_q     = 1'b1;
    int                            done_count  = 0;
    int                            cycle_count = 0;

    sdmac_cpu_bus dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .dir        (dir),
        .bgrant_n   (bgrant_n),
        .dsack      (dsack),
        .sterm_n    (sterm_n),
        .fill       (fill),
        .fill_full  (fill_full),
        .breq_n     (breq_n),
        .bgack_n    (bgack_n),
        .as_n       (as_n),
        .ds_n       (ds_n),
        .size1      (size1),
        .f2cpul     (f2cpul),
        .f2cpuh     (f2cpuh),
        .pllw       (pllw),
        .plhw       (plhw),
        .fifo_count (fifo_count),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

    bind sdmac_cpu_bus sdmac_cpu_bus_props props_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .breq_n   (breq_n),
        .bgack_n  (bgack_n),
        .as_n     (as_n),
        .inc_fifo (inc_fifo),
        .dec_fifo (dec_fifo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Words moved until the FIFO runs out toward the bus or fills from it
    function automatic result_t expected_result(input int start_count, input logic to_bus,
                                                input logic wide16);
        result_t r;
        int      words;
        words = to_bus ? start_count : `CPU_SM_FIFO_DEPTH - start_count;
        r = '0;
        if (to_bus) begin
            r[0] = words[`CPU_SM_CNT_W-1:0];
            r[1] = words[`CPU_SM_CNT_W-1:0];
        end else begin
            r[2] = words[`CPU_SM_CNT_W-1:0];
            r[3] = words[`CPU_SM_CNT_W-1:0];
            r[5] = `CPU_SM_FIFO_DEPTH;
        end
        // Only a 16-bit port runs a second half per longword
        if (wide16) begin
            r[4] = words[`CPU_SM_CNT_W-1:0];
        end
        return r;
    endfunction

    function automatic logic [`CPU_SM_CNT_W-1:0] sat_inc(input logic [`CPU_SM_CNT_W-1:0] cnt,
                                                         input logic hit);
        return (hit && cnt != '1) ? cnt + 1'b1 : cnt;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic count_compare(input string name, input logic [`CPU_SM_CNT_W-1:0] got,
                                 input logic [`CPU_SM_CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic strobe_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic reset_dut();
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic preload_fifo(input int words);
        if (words == `CPU_SM_FIFO_DEPTH) begin
            fill_full <= 1'b1;
            @(posedge clk);
            fill_full <= 1'b0;
        end else if (words > 0) begin
            fill <= 1'b1;
            repeat (words) @(posedge clk);
            fill <= 1'b0;
        end
        @(posedge clk);
        count_compare("fifo_count", fifo_count, words[`CPU_SM_CNT_W-1:0]);
        strobe_compare("fifo_empty", fifo_empty, words == 0);
        strobe_compare("fifo_full", fifo_full, words == `CPU_SM_FIFO_DEPTH);
    endtask

    task automatic start_ignored(input logic to_bus);
        dir   <= to_bus;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (6) begin
            @(posedge clk);
            strobe_compare("breq_n", breq_n, 1'b1);
        end
    endtask

    task automatic run_transfer(input int words, input logic to_bus, input logic wide16);
        int done_before;
        reset_dut();
        preload_fifo(words);
        expected    = expected_result(words, to_bus, wide16);
        port16      = wide16;
        done_before = done_count;
        dir   <= to_bus;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // The compare process counts a transfer when bgack_n rises
        while (done_count == done_before) begin
            @(posedge clk);
        end
    endtask

    // Arbiter side of the bus
    initial begin : grant_model
        forever begin
            @(posedge clk);
            if (rst_n && !breq_n && bgrant_n) begin
                strobe_compare("bgack_n", bgack_n, 1'b1);
                repeat ($urandom_range(5, 0)) @(posedge clk);
                bgrant_n <= 1'b0;
                @(posedge clk);
                strobe_compare("bgack_n", bgack_n, 1'b1);
                @(posedge clk);
                strobe_compare("bgack_n", bgack_n, 1'b0);
                strobe_compare("breq_n", breq_n, 1'b1);
                bgrant_n <= 1'b1;
            end
        end
    end

    // Memory port: one termination per bus cycle after some wait states
    initial begin : port_model
        int                       wait_cycles;
        logic [`CPU_SM_CNT_W-1:0] count_seen;
        forever begin
            @(posedge clk);
            if (rst_n && !as_n) begin
                wait_cycles  = (stall_cycles != 0) ? stall_cycles : $urandom_range(6, 0);
                stall_cycles = 0;
                count_seen   = fifo_count;
                repeat (wait_cycles) begin
                    @(posedge clk);
                    strobe_compare("as_n", as_n, 1'b0);
                    strobe_compare("ds_n", ds_n, 1'b0);
                    count_compare("fifo_count", fifo_count, count_seen);
                end
                if (port16) begin
                    dsack <= 1'b1;
                end else begin
                    sterm_n <= 1'b0;
                end
                @(posedge clk);
                dsack   <= 1'b0;
                sterm_n <= 1'b1;
                do begin
                    @(posedge clk);
                end while (!as_n);
            end
        end
    end

    // Counts strobes and checks a transfer once the bus is released
    always @(posedge clk) begin
        if (!rst_n) begin
            pulses <= '0;
        end else begin
            pulses[0] <= sat_inc(pulses[0], f2cpul);
            pulses[1] <= sat_inc(pulses[1], f2cpuh);
            pulses[2] <= sat_inc(pulses[2], pllw);
            pulses[3] <= sat_inc(pulses[3], plhw);
            pulses[4] <= sat_inc(pulses[4], size1 & ~size1_q);
            // Low half alone on a 16-bit port
            if (port16 && (f2cpul || pllw)) begin
                strobe_compare("f2cpuh", f2cpuh, 1'b0);
                strobe_compare("plhw", plhw, 1'b0);
            end
            // Both words of the running direction in one cycle on a 32-bit port
            if (!port16 && (f2cpul || f2cpuh || pllw || plhw)) begin
                strobe_compare("f2cpul", f2cpul, dir);
                strobe_compare("f2cpuh", f2cpuh, dir);
                strobe_compare("pllw", pllw, ~dir);
                strobe_compare("plhw", plhw, ~dir);
            end
            if (bgack_n && !bgack_q) begin
                count_compare("f2cpul pulses", pulses[0], expected[0]);
                count_compare("f2cpuh pulses", pulses[1], expected[1]);
                count_compare("pllw pulses", pulses[2], expected[2]);
                count_compare("plhw pulses", pulses[3], expected[3]);
                count_compare("size1 halves", pulses[4], expected[4]);
                count_compare("fifo_count", fifo_count, expected[5]);
                strobe_compare("fifo_empty", fifo_empty, expected[5] == '0);
                strobe_compare("fifo_full", fifo_full, expected[5] == `CPU_SM_FIFO_DEPTH);
                done_count <= done_count + 1;
            end
        end
        size1_q <= size1;
        bgack_q <= bgack_n;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end else if (dut_i.props_i.prop_failures != 0) begin
            $display("A bus protocol assertion on the DUT failed");
            abort_run();
        end
    end

    initial begin : main_seq
        int   run_idx;
        int   run_words;
        logic run_dir;
        logic run_wide;
        void'($urandom(32'h30dcdaf1));
        rst_n        = 1'b0;
        start        = 1'b0;
        dir          = 1'b0;
        bgrant_n     = 1'b1;
        dsack        = 1'b0;
        sterm_n      = 1'b1;
        fill         = 1'b0;
        fill_full    = 1'b0;
        port16       = 1'b0;
        stall_cycles = 0;
        expected     = '0;

        reset_dut();
        strobe_compare("breq_n", breq_n, 1'b1);
        strobe_compare("bgack_n", bgack_n, 1'b1);
        strobe_compare("as_n", as_n, 1'b1);
        strobe_compare("ds_n", ds_n, 1'b1);
        strobe_compare("size1", size1, 1'b0);
        strobe_compare("f2cpul", f2cpul, 1'b0);
        strobe_compare("f2cpuh", f2cpuh, 1'b0);
        strobe_compare("pllw", pllw, 1'b0);
        strobe_compare("plhw", plhw, 1'b0);
        count_compare("fifo_count", fifo_count, '0);
        strobe_compare("fifo_empty", fifo_empty, 1'b1);
        strobe_compare("fifo_full", fifo_full, 1'b0);

        // Nothing to send, then nowhere to put data
        start_ignored(1'b1);
        preload_fifo(`CPU_SM_FIFO_DEPTH);
        start_ignored(1'b0);

        run_transfer(`CPU_SM_FIFO_DEPTH, 1'b1, 1'b0);
        run_transfer(0, 1'b0, 1'b1);

        // First bus cycle held off by the port
        stall_cycles = 20;
        run_transfer(5, 1'b1, 1'b1);

        for (run_idx = 0; run_idx < RANDOM_RUNS; run_idx++) begin
            run_dir   = ($urandom_range(1, 0) == 1);
            run_wide  = ($urandom_range(1, 0) == 1);
            run_words = run_dir ? $urandom_range(`CPU_SM_FIFO_DEPTH, 1)
                                : $urandom_range(`CPU_SM_FIFO_DEPTH - 1, 0);
            run_transfer(run_words, run_dir, run_wide);
        end

        if (dut_i.props_i.prop_failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sdmac_cpu_bus.f */
+incdir+common
common/cpu_sm_pkg.sv
hw/fifo_ptr_ctrl.sv
hw/cpu_sm/cpu_sm_state.sv
hw/cpu_sm/cpu_sm_terms.sv
hw/cpu_sm/cpu_sm_outputs.sv
hw/sdmac_cpu_bus.sv
verification/sdmac_cpu_bus_props.sv
verification/sdmac_cpu_bus_tb.sv

/* Bender.yml */
package:
  name: sdmac_cpu_bus

export_include_dirs:
  - common

sources:
  - common/cpu_sm_pkg.sv
  - hw/fifo_ptr_ctrl.sv
  - hw/cpu_sm/cpu_sm_state.sv
  - hw/cpu_sm/cpu_sm_terms.sv
  - hw/cpu_sm/cpu_sm_outputs.sv
  - hw/sdmac_cpu_bus.sv
  - target: test
    files:
      - verification/sdmac_cpu_bus_props.sv
      - verification/sdmac_cpu_bus_tb.sv
